//--- Makefile
VERILATOR ?= verilator
TOP       ?= mini_mcu_tb
FILELIST  ?= mini_mcu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(BUILD_DIR)

//--- ao_peripheral/ao_peripheral_subsystem.sv
// always-on peripheral block
// GPIO, power-control register and rising-edge interrupts
`default_nettype none

module ao_peripheral_subsystem (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic                                 sel_i,
  input  mini_mcu_pkg::bus_op_e                op_i,
  input  logic [mini_mcu_pkg::BANK_IDX_W-1:0]  idx_i,
  input  logic [mini_mcu_pkg::DATA_W-1:0]      wdata_i,
  output logic [mini_mcu_pkg::DATA_W-1:0]      rdata_o,
  input  logic [mini_mcu_pkg::GPIO_W-1:0]      gpio_i,
  output logic [mini_mcu_pkg::GPIO_W-1:0]      gpio_o,
  output logic [mini_mcu_pkg::GPIO_W-1:0]      gpio_oe_o,
  output logic [mini_mcu_pkg::NUM_DOMAINS-1:0] pwr_req_o,
  output logic                                 irq_valid_o,
  output logic [mini_mcu_pkg::IRQ_ID_W-1:0]    irq_id_o
);

  import mini_mcu_pkg::*;

  logic                   reg_hit;
  logic                   wr_en;
  logic [REG_OFF_W-1:0]   reg_off;
  logic [GPIO_W-1:0]      sync1_q;
  logic [GPIO_W-1:0]      sync2_q;
  logic [GPIO_W-1:0]      sync3_q;
  logic [GPIO_W-1:0]      rise;
  logic [GPIO_W-1:0]      irq_clr;
  logic [GPIO_W-1:0]      irq_pend_q;
  logic [NUM_DOMAINS-1:0] pwr_ctrl_q;
  logic [DATA_W-1:0]      rd_val;

  assign reg_hit = sel_i && (idx_i[BANK_IDX_W-1:REG_OFF_W] == '0);
  assign reg_off = idx_i[REG_OFF_W-1:0];
  assign wr_en   = reg_hit && op_i == OP_WRITE;

  // third stage only remembers the last synced level
  assign rise    = sync2_q & ~sync3_q;
  assign irq_clr = (wr_en && reg_off == REG_IRQ_PENDING) ? wdata_i[GPIO_W-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q    <= '0;
      sync2_q    <= '0;
      sync3_q    <= '0;
      irq_pend_q <= '0;
      gpio_o     <= '0;
      gpio_oe_o  <= '0;
      pwr_ctrl_q <= '0;
    end else begin
      sync1_q    <= gpio_i;
      sync2_q    <= sync1_q;
      sync3_q    <= sync2_q;
      // a new edge wins over a clear in the same cycle
      irq_pend_q <= (irq_pend_q & ~irq_clr) | rise;
      if (wr_en) begin
        case (reg_off)
          REG_GPIO_OUT: gpio_o <= wdata_i[GPIO_W-1:0];
          REG_GPIO_OE:  gpio_oe_o <= wdata_i[GPIO_W-1:0];
          REG_PWR_CTRL: pwr_ctrl_q <= wdata_i[NUM_DOMAINS-1:0];
          default:      ;
        endcase
      end
    end
  end

  always_comb begin
    rd_val = '0;
    case (reg_off)
      REG_GPIO_OUT:    rd_val = DATA_W'(gpio_o);
      REG_GPIO_OE:     rd_val = DATA_W'(gpio_oe_o);
      REG_GPIO_IN:     rd_val = DATA_W'(sync2_q);
      REG_PWR_CTRL:    rd_val = DATA_W'(pwr_ctrl_q);
      REG_IRQ_PENDING: rd_val = DATA_W'(irq_pend_q);
      default:         rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rdata_o <= reg_hit ? rd_val : '0;
    end
  end

  assign pwr_req_o   = pwr_ctrl_q;
  assign irq_valid_o = |irq_pend_q;

  // lowest pending pin has priority
  always_comb begin
    irq_id_o = '0;
    for (int i = GPIO_W - 1; i >= 0; i--) begin
      if (irq_pend_q[i]) begin
        irq_id_o = IRQ_ID_W'(i);
      end
    end
  end

endmodule

`default_nettype wire

//--- common/mini_mcu_pkg.sv
// mini_mcu shared definitions
// address map, bus widths, register offsets and state encodings
`default_nettype none

package mini_mcu_pkg;

  localparam int ADDR_W      = 12;
  localparam int DATA_W      = 32;
  localparam int NUM_BANKS   = 2;
  localparam int BANK_WORDS  = 64;
  localparam int BANK_IDX_W  = 6;
  localparam int GPIO_W      = 8;
  localparam int IRQ_ID_W    = 3;
  localparam int NUM_TARGETS = 4;

  // response queue depth follows the credit count
  localparam int BUS_CREDITS = 2;
  localparam int BUS_PTR_W   = $clog2(BUS_CREDITS);
  localparam int BUS_CNT_W   = $clog2(BUS_CREDITS + 1);

  // domain 0 is the peripheral, banks follow from 1
  localparam int NUM_DOMAINS = 3;
  localparam int DOM_PERIPH  = 0;
  localparam int DOM_BANK0   = 1;

  localparam int REG_OFF_W = 3;
  localparam logic [REG_OFF_W-1:0] REG_GPIO_OUT    = 3'd0;
  localparam logic [REG_OFF_W-1:0] REG_GPIO_OE     = 3'd1;
  localparam logic [REG_OFF_W-1:0] REG_GPIO_IN     = 3'd2;
  localparam logic [REG_OFF_W-1:0] REG_PWR_CTRL    = 3'd3;
  localparam logic [REG_OFF_W-1:0] REG_IRQ_PENDING = 3'd4;

  // region from address bits 11:10
  typedef enum logic [1:0] {
    TGT_BANK0,
    TGT_BANK1,
    TGT_AO_PERIPH,
    TGT_PERIPH
  } target_e;

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } bus_op_e;

  typedef enum logic [1:0] {
    PWR_ON,
    PWR_GATING,
    PWR_OFF,
    PWR_UNGATING
  } pwr_state_e;

endpackage

`default_nettype wire

//--- memory_subsystem/memory_bank.sv
// one SRAM bank, word addressed, retentive across clock gating and reset
`default_nettype none

module memory_bank (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                clk_en_i,
  input  logic                                sel_i,
  input  mini_mcu_pkg::bus_op_e               op_i,
  input  logic [mini_mcu_pkg::BANK_IDX_W-1:0] idx_i,
  input  logic [mini_mcu_pkg::DATA_W-1:0]     wdata_i,
  output logic [mini_mcu_pkg::DATA_W-1:0]     rdata_o
);

  import mini_mcu_pkg::*;

  logic [DATA_W-1:0] mem_q [BANK_WORDS];

  // storage only moves while the bank clock runs
  always_ff @(posedge clk_i) begin
    if (clk_en_i && sel_i && op_i == OP_WRITE) begin
      mem_q[idx_i] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rdata_o <= '0;
    end else if (clk_en_i && sel_i) begin
      rdata_o <= mem_q[idx_i];
    end
  end

endmodule

`default_nettype wire

//--- mini_mcu.f
common/mini_mcu_pkg.sv
system_bus/system_bus.sv
memory_subsystem/memory_bank.sv
rtl/power_manager.sv
ao_peripheral/ao_peripheral_subsystem.sv
rtl/peripheral_subsystem.sv
rtl/mini_mcu.sv
tests/mini_mcu_properties.sv
tests/mini_mcu_tb.sv

//--- rtl/mini_mcu.sv
// mini_mcu top level
// system bus, two SRAM banks, always-on and switchable peripherals, power manager
`default_nettype none

module mini_mcu (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                req_valid_i,
  input  mini_mcu_pkg::bus_op_e               req_op_i,
  input  logic [mini_mcu_pkg::ADDR_W-1:0]     req_addr_i,
  input  logic [mini_mcu_pkg::DATA_W-1:0]     req_wdata_i,
  input  logic                                rsp_ready_i,
  output logic                                rsp_valid_o,
  output logic [mini_mcu_pkg::DATA_W-1:0]     rsp_rdata_o,
  output logic                                rsp_err_o,
  output logic                                credit_o,
  input  logic [mini_mcu_pkg::GPIO_W-1:0]     ao_gpio_i,
  output logic [mini_mcu_pkg::GPIO_W-1:0]     ao_gpio_o,
  output logic [mini_mcu_pkg::GPIO_W-1:0]     ao_gpio_oe_o,
  input  logic [mini_mcu_pkg::GPIO_W-1:0]     gpio_i,
  output logic [mini_mcu_pkg::GPIO_W-1:0]     gpio_o,
  output logic [mini_mcu_pkg::GPIO_W-1:0]     gpio_oe_o,
  output logic                                irq_valid_o,
  output logic [mini_mcu_pkg::IRQ_ID_W-1:0]   irq_id_o
);

  import mini_mcu_pkg::*;

  logic [NUM_TARGETS-1:0]             tgt_sel;
  bus_op_e                            tgt_op;
  logic [BANK_IDX_W-1:0]              tgt_idx;
  logic [DATA_W-1:0]                  tgt_wdata;
  logic [NUM_TARGETS-1:0][DATA_W-1:0] tgt_rdata;
  logic [NUM_DOMAINS-1:0]             pwr_req;
  logic [NUM_DOMAINS-1:0]             clk_en;
  logic [NUM_DOMAINS-1:0]             domain_rst;
  logic [NUM_DOMAINS-1:0]             domain_off;

  system_bus u_system_bus (
    .clk_i, .rst_i,
    .req_valid_i, .req_op_i, .req_addr_i, .req_wdata_i,
    .rsp_ready_i, .rsp_valid_o, .rsp_rdata_o, .rsp_err_o, .credit_o,
    .tgt_sel_o   (tgt_sel),
    .tgt_op_o    (tgt_op),
    .tgt_idx_o   (tgt_idx),
    .tgt_wdata_o (tgt_wdata),
    .tgt_rdata_i (tgt_rdata),
    .domain_off_i(domain_off)
  );

  // bank b sits on target b and power domain DOM_BANK0 + b
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    memory_bank u_bank (
      .clk_i,
      .rst_i   (domain_rst[DOM_BANK0+b]),
      .clk_en_i(clk_en[DOM_BANK0+b]),
      .sel_i   (tgt_sel[b]),
      .op_i    (tgt_op),
      .idx_i   (tgt_idx),
      .wdata_i (tgt_wdata),
      .rdata_o (tgt_rdata[b])
    );
  end

  ao_peripheral_subsystem u_ao_periph (
    .clk_i, .rst_i,
    .sel_i      (tgt_sel[TGT_AO_PERIPH]),
    .op_i       (tgt_op),
    .idx_i      (tgt_idx),
    .wdata_i    (tgt_wdata),
    .rdata_o    (tgt_rdata[TGT_AO_PERIPH]),
    .gpio_i     (ao_gpio_i),
    .gpio_o     (ao_gpio_o),
    .gpio_oe_o  (ao_gpio_oe_o),
    .pwr_req_o  (pwr_req),
    .irq_valid_o, .irq_id_o
  );

  peripheral_subsystem u_periph (
    .clk_i, .rst_i,
    .clk_en_i    (clk_en[DOM_PERIPH]),
    .domain_rst_i(domain_rst[DOM_PERIPH]),
    .sel_i       (tgt_sel[TGT_PERIPH]),
    .op_i        (tgt_op),
    .idx_i       (tgt_idx),
    .wdata_i     (tgt_wdata),
    .rdata_o     (tgt_rdata[TGT_PERIPH]),
    .gpio_i, .gpio_o, .gpio_oe_o
  );

  power_manager u_power_manager (
    .clk_i, .rst_i,
    .pwr_req_i   (pwr_req),
    .clk_en_o    (clk_en),
    .domain_rst_o(domain_rst),
    .domain_off_o(domain_off)
  );

endmodule

`default_nettype wire

//--- rtl/peripheral_subsystem.sv
// switchable peripheral block, GPIO registers in a gated power domain
`default_nettype none

module peripheral_subsystem (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                clk_en_i,
  input  logic                                domain_rst_i,
  input  logic                                sel_i,
  input  mini_mcu_pkg::bus_op_e               op_i,
  input  logic [mini_mcu_pkg::BANK_IDX_W-1:0] idx_i,
  input  logic [mini_mcu_pkg::DATA_W-1:0]     wdata_i,
  output logic [mini_mcu_pkg::DATA_W-1:0]     rdata_o,
  input  logic [mini_mcu_pkg::GPIO_W-1:0]     gpio_i,
  output logic [mini_mcu_pkg::GPIO_W-1:0]     gpio_o,
  output logic [mini_mcu_pkg::GPIO_W-1:0]     gpio_oe_o
);

  import mini_mcu_pkg::*;

  logic                 reg_rst;
  logic                 reg_hit;
  logic [REG_OFF_W-1:0] reg_off;
  logic [GPIO_W-1:0]    sync1_q;
  logic [GPIO_W-1:0]    sync2_q;
  logic [GPIO_W-1:0]    rd_val;

  assign reg_rst = rst_i || domain_rst_i;
  assign reg_hit = sel_i && (idx_i[BANK_IDX_W-1:REG_OFF_W] == '0);
  assign reg_off = idx_i[REG_OFF_W-1:0];

  always_ff @(posedge clk_i) begin
    if (reg_rst) begin
      sync1_q   <= '0;
      sync2_q   <= '0;
      gpio_o    <= '0;
      gpio_oe_o <= '0;
    end else if (clk_en_i) begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      if (reg_hit && op_i == OP_WRITE && reg_off == REG_GPIO_OUT) begin
        gpio_o <= wdata_i[GPIO_W-1:0];
      end
      if (reg_hit && op_i == OP_WRITE && reg_off == REG_GPIO_OE) begin
        gpio_oe_o <= wdata_i[GPIO_W-1:0];
      end
    end
  end

  // power and interrupt offsets live in the ao block only
  always_comb begin
    case (reg_off)
      REG_GPIO_OUT: rd_val = gpio_o;
      REG_GPIO_OE:  rd_val = gpio_oe_o;
      REG_GPIO_IN:  rd_val = sync2_q;
      default:      rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (clk_en_i && sel_i) begin
      rdata_o <= reg_hit ? DATA_W'(rd_val) : '0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/power_manager.sv
// power manager, one sequencer per switchable domain
// gates the clock before reset on the way down, releases reset first on the way up
`default_nettype none

module power_manager (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic [mini_mcu_pkg::NUM_DOMAINS-1:0] pwr_req_i,
  output logic [mini_mcu_pkg::NUM_DOMAINS-1:0] clk_en_o,
  output logic [mini_mcu_pkg::NUM_DOMAINS-1:0] domain_rst_o,
  output logic [mini_mcu_pkg::NUM_DOMAINS-1:0] domain_off_o
);

  import mini_mcu_pkg::*;

  for (genvar d = 0; d < NUM_DOMAINS; d++) begin : g_dom
    pwr_state_e state_q;
    pwr_state_e state_d;

    always_comb begin
      state_d = state_q;
      case (state_q)
        PWR_ON:       if (pwr_req_i[d]) state_d = PWR_GATING;
        PWR_GATING:   state_d = PWR_OFF;
        PWR_OFF:      if (!pwr_req_i[d]) state_d = PWR_UNGATING;
        PWR_UNGATING: state_d = PWR_ON;
        default:      state_d = PWR_ON;
      endcase
    end

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        state_q <= PWR_ON;
      end else begin
        state_q <= state_d;
      end
    end

    assign clk_en_o[d]     = (state_q == PWR_ON);
    assign domain_rst_o[d] = (state_q == PWR_OFF);
    // busy transitions count as off for the bus
    assign domain_off_o[d] = (state_q != PWR_ON);
  end

endmodule

`default_nettype wire

//--- system_bus/system_bus.sv
// system bus with address decode and credit flow control
// responses return in order through a small queue
`default_nettype none

module system_bus (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic                                 req_valid_i,
  input  mini_mcu_pkg::bus_op_e                req_op_i,
  input  logic [mini_mcu_pkg::ADDR_W-1:0]      req_addr_i,
  input  logic [mini_mcu_pkg::DATA_W-1:0]      req_wdata_i,
  input  logic                                 rsp_ready_i,
  output logic                                 rsp_valid_o,
  output logic [mini_mcu_pkg::DATA_W-1:0]      rsp_rdata_o,
  output logic                                 rsp_err_o,
  output logic                                 credit_o,
  output logic [mini_mcu_pkg::NUM_TARGETS-1:0] tgt_sel_o,
  output mini_mcu_pkg::bus_op_e                tgt_op_o,
  output logic [mini_mcu_pkg::BANK_IDX_W-1:0]  tgt_idx_o,
  output logic [mini_mcu_pkg::DATA_W-1:0]      tgt_wdata_o,
  input  logic [mini_mcu_pkg::NUM_TARGETS-1:0][mini_mcu_pkg::DATA_W-1:0] tgt_rdata_i,
  input  logic [mini_mcu_pkg::NUM_DOMAINS-1:0] domain_off_i
);

  import mini_mcu_pkg::*;

  target_e              req_tgt;
  logic                 req_off;
  logic                 pend_valid;
  target_e              pend_tgt;
  bus_op_e              pend_op;
  logic                 pend_err;
  logic [DATA_W:0]      push_data;
  logic [DATA_W:0]      q_mem [BUS_CREDITS];
  logic [BUS_PTR_W-1:0] wr_ptr;
  logic [BUS_PTR_W-1:0] rd_ptr;
  logic [BUS_CNT_W-1:0] q_count;
  logic                 push;
  logic                 pop;

  assign req_tgt = target_e'(req_addr_i[ADDR_W-1 -: 2]);

  // ao block has no domain and never reports off
  always_comb begin
    case (req_tgt)
      TGT_BANK0:  req_off = domain_off_i[DOM_BANK0];
      TGT_BANK1:  req_off = domain_off_i[DOM_BANK0+1];
      TGT_PERIPH: req_off = domain_off_i[DOM_PERIPH];
      default:    req_off = 1'b0;
    endcase
  end

  assign tgt_sel_o   = (req_valid_i && !req_off) ? (NUM_TARGETS'(1) << req_tgt) : '0;
  assign tgt_op_o    = req_op_i;
  assign tgt_idx_o   = req_addr_i[BANK_IDX_W-1:0];
  assign tgt_wdata_o = req_wdata_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_valid <= 1'b0;
    end else begin
      pend_valid <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    pend_tgt <= req_tgt;
    pend_op  <= req_op_i;
    pend_err <= req_off;
  end

  // {err, rdata}; writes and errors carry zero data
  always_comb begin
    push_data = '0;
    if (pend_err) begin
      push_data[DATA_W] = 1'b1;
    end else if (pend_op == OP_READ) begin
      push_data[DATA_W-1:0] = tgt_rdata_i[pend_tgt];
    end
  end

  assign push = pend_valid;
  assign pop  = rsp_valid_o && rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == BUS_PTR_W'(BUS_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == BUS_PTR_W'(BUS_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
      end
      q_count <= q_count + BUS_CNT_W'(push) - BUS_CNT_W'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      q_mem[wr_ptr] <= push_data;
    end
  end

  assign rsp_valid_o              = (q_count != '0);
  assign {rsp_err_o, rsp_rdata_o} = q_mem[rd_ptr];
  // each popped response hands one credit back
  assign credit_o                 = pop;

endmodule

`default_nettype wire

//--- tests/mini_mcu_properties.sv
// credit protocol checks on the system bus
`default_nettype none

module mini_mcu_properties (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                req_valid_i,
  input  logic                                credit_o,
  input  logic                                pend_valid,
  input  logic [mini_mcu_pkg::BUS_CNT_W-1:0]  q_count
);

  timeunit 1ns;
  timeprecision 1ps;

  import mini_mcu_pkg::*;

  localparam int CW = BUS_CNT_W + 1;

  // credits held by the master
  logic [CW-1:0] credits;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      credits <= CW'(BUS_CREDITS);
    end else begin
      credits <= credits - CW'(req_valid_i) + CW'(credit_o);
    end
  end

  a_no_req_without_credit: assert property (
    @(posedge clk_i) disable iff (rst_i) req_valid_i |-> credits != '0
  ) else $error("request issued with no credit left");

  // each credit is with the master, in flight or queued
  a_credit_conserved: assert property (
    @(posedge clk_i) disable iff (rst_i)
      int'(credits) + int'(q_count) + int'(pend_valid) == BUS_CREDITS
  ) else $error("credit return does not match popped responses");

  a_queue_bound: assert property (
    @(posedge clk_i) disable iff (rst_i) q_count <= BUS_CNT_W'(BUS_CREDITS)
  ) else $error("response queue overflow");

endmodule

bind system_bus mini_mcu_properties u_props (.*);

`default_nettype wire

//--- tests/mini_mcu_tb.sv
// mini_mcu testbench
// bus driver, reference model of memories and registers, in-order response compare
`default_nettype none

module mini_mcu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import mini_mcu_pkg::*;

  localparam int TIMEOUT = 200;

  logic              clk_i;
  logic              rst_i;
  logic              req_valid_i;
  bus_op_e           req_op_i;
  logic [ADDR_W-1:0] req_addr_i;
  logic [DATA_W-1:0] req_wdata_i;
  logic              rsp_ready_i;
  logic              rsp_valid_o;
  logic [DATA_W-1:0] rsp_rdata_o;
  logic              rsp_err_o;
  logic              credit_o;
  logic [GPIO_W-1:0] ao_gpio_i;
  logic [GPIO_W-1:0] ao_gpio_o;
  logic [GPIO_W-1:0] ao_gpio_oe_o;
  logic [GPIO_W-1:0] gpio_i;
  logic [GPIO_W-1:0] gpio_o;
  logic [GPIO_W-1:0] gpio_oe_o;
  logic              irq_valid_o;
  logic [IRQ_ID_W-1:0] irq_id_o;

  // reference state
  logic [DATA_W-1:0]      mem_m [NUM_BANKS][BANK_WORDS];
  logic [GPIO_W-1:0]      ao_out_m;
  logic [GPIO_W-1:0]      ao_oe_m;
  logic [GPIO_W-1:0]      per_out_m;
  logic [GPIO_W-1:0]      per_oe_m;
  logic [NUM_DOMAINS-1:0] pwr_m;
  logic [DATA_W:0]        exp_q [$];
  logic [31:0]            rng_state;
  logic [ADDR_W-1:0]      wr_addr [8];
  int errors;
  int issued;
  int returned;

  mini_mcu dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // expected {err, rdata} of one access; updates the model
  function automatic logic [DATA_W:0] reference(bus_op_e op, logic [ADDR_W-1:0] addr,
                                               logic [DATA_W-1:0] wdata);
    logic [1:0]        tgt;
    logic [5:0]        idx;
    logic [2:0]        off;
    logic [DATA_W-1:0] rd;
    logic              err;
    tgt = addr[11:10];
    idx = addr[5:0];
    off = idx[2:0];
    rd = '0;
    err = 1'b0;
    if (tgt < 2'd2) begin
      if (pwr_m[1 + int'(tgt)]) err = 1'b1;
      else if (op == OP_WRITE) mem_m[tgt[0]][idx] = wdata;
      else rd = mem_m[tgt[0]][idx];
    end else if (tgt == 2'd3 && pwr_m[0]) begin
      err = 1'b1;
    end else if (idx[5:3] == 3'd0) begin
      if (tgt == 2'd2 && op == OP_WRITE) begin
        case (off)
          3'd0: ao_out_m = wdata[GPIO_W-1:0];
          3'd1: ao_oe_m = wdata[GPIO_W-1:0];
          3'd3: pwr_m = wdata[NUM_DOMAINS-1:0];
          default: ;
        endcase
        // peripheral registers clear while its domain is off
        if (off == 3'd3 && wdata[0]) begin
          per_out_m = '0;
          per_oe_m = '0;
        end
      end else if (op == OP_WRITE) begin
        if (off == 3'd0) per_out_m = wdata[GPIO_W-1:0];
        if (off == 3'd1) per_oe_m = wdata[GPIO_W-1:0];
      end else begin
        case (off)
          3'd0: rd = {24'd0, (tgt == 2'd2) ? ao_out_m : per_out_m};
          3'd1: rd = {24'd0, (tgt == 2'd2) ? ao_oe_m : per_oe_m};
          3'd2: rd = {24'd0, (tgt == 2'd2) ? ao_gpio_i : gpio_i};
          3'd3: rd = (tgt == 2'd2) ? {29'd0, pwr_m} : '0;
          default: rd = '0;
        endcase
      end
    end
    if (op == OP_WRITE) rd = '0;
    return {err, rd};
  endfunction

  task automatic check(input string name, input logic [DATA_W-1:0] got,
                       input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("test failed");
    $finish;
  endtask

  task automatic send(input bus_op_e op, input logic [ADDR_W-1:0] addr,
                      input logic [DATA_W-1:0] wdata);
    int waited;
    waited = 0;
    @(posedge clk_i);
    while (BUS_CREDITS - issued + returned <= 0) begin
      waited++;
      if (waited > TIMEOUT) abort_on_timeout("a bus credit");
      @(posedge clk_i);
    end
    req_valid_i <= 1'b1;
    req_op_i <= op;
    req_addr_i <= addr;
    req_wdata_i <= wdata;
    issued++;
    exp_q.push_back(reference(op, addr, wdata));
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > TIMEOUT) abort_on_timeout("outstanding responses");
      @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
  endtask

  task automatic wait_irq(input logic valid, input logic [IRQ_ID_W-1:0] id);
    int waited;
    waited = 0;
    @(posedge clk_i);
    while (irq_valid_o !== valid || (valid && irq_id_o !== id)) begin
      waited++;
      if (waited > TIMEOUT) abort_on_timeout("the interrupt output");
      @(posedge clk_i);
    end
  endtask

  // compares responses in request order and returns credits
  always @(posedge clk_i) begin
    logic [DATA_W:0] exp;
    if (!rst_i) begin
      returned <= returned + int'(credit_o);
      if (rsp_valid_o && rsp_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("response arrived with no request outstanding");
          errors++;
        end else begin
          exp = exp_q.pop_front();
          check("rsp_rdata_o", rsp_rdata_o, exp[DATA_W-1:0]);
          check("rsp_err_o", 32'(rsp_err_o), 32'(exp[DATA_W]));
        end
      end
    end
  end

  initial begin
    rst_i = 1'b1;
    req_valid_i = 1'b0;
    req_op_i = OP_READ;
    req_addr_i = '0;
    req_wdata_i = '0;
    rsp_ready_i = 1'b1;
    ao_gpio_i = '0;
    gpio_i = '0;
    ao_out_m = '0;
    ao_oe_m = '0;
    per_out_m = '0;
    per_oe_m = '0;
    pwr_m = '0;
    rng_state = 32'd68;
    errors = 0;
    issued = 0;
    returned = 0;
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;

    // random bank writes, alternating banks, then read back
    for (int i = 0; i < 8; i++) begin
      wr_addr[i] = {1'b0, 1'(i), 4'd0, 6'(next_rand())};
      send(OP_WRITE, wr_addr[i], next_rand());
    end
    for (int i = 0; i < 8; i++) send(OP_READ, wr_addr[i], '0);
    drain();

    // back-pressure holds credits until ready returns
    rsp_ready_i <= 1'b0;
    send(OP_READ, wr_addr[0], '0);
    send(OP_READ, wr_addr[1], '0);
    // third request waits for a returned credit
    fork
      send(OP_READ, wr_addr[2], '0);
      begin
        repeat (6) begin
          @(posedge clk_i);
          check("credit_o", 32'(credit_o), 32'd0);
        end
        check("rsp_valid_o", 32'(rsp_valid_o), 32'd1);
        rsp_ready_i <= 1'b1;
      end
    join
    drain();

    // GPIO on both groups
    send(OP_WRITE, 12'h800, 32'hA5);
    send(OP_WRITE, 12'h801, 32'h3C);
    send(OP_WRITE, 12'hC00, 32'h5A);
    send(OP_WRITE, 12'hC01, 32'hC3);
    drain();
    check("ao_gpio_o", 32'(ao_gpio_o), 32'hA5);
    check("ao_gpio_oe_o", 32'(ao_gpio_oe_o), 32'h3C);
    check("gpio_o", 32'(gpio_o), 32'h5A);
    check("gpio_oe_o", 32'(gpio_oe_o), 32'hC3);
    ao_gpio_i <= 8'h81;
    gpio_i <= 8'h66;
    repeat (4) @(posedge clk_i);
    send(OP_READ, 12'h802, '0);
    send(OP_READ, 12'hC02, '0);
    send(OP_READ, 12'hC06, '0);
    drain();

    // bank 1 off, then back with contents kept
    send(OP_WRITE, 12'h407, 32'h1234);
    send(OP_WRITE, 12'h803, 32'h4);
    drain();
    repeat (4) @(posedge clk_i);
    send(OP_READ, 12'h407, '0);
    send(OP_WRITE, 12'h407, 32'hDEAD);
    send(OP_WRITE, 12'h803, 32'h0);
    drain();
    repeat (4) @(posedge clk_i);
    send(OP_READ, 12'h407, '0);
    drain();

    // peripheral off clears its registers
    send(OP_WRITE, 12'h803, 32'h1);
    drain();
    repeat (4) @(posedge clk_i);
    check("gpio_o", 32'(gpio_o), 32'h0);
    check("gpio_oe_o", 32'(gpio_oe_o), 32'h0);
    send(OP_READ, 12'hC00, '0);
    send(OP_WRITE, 12'h803, 32'h0);
    drain();
    repeat (4) @(posedge clk_i);
    send(OP_READ, 12'hC00, '0);
    send(OP_READ, 12'hC01, '0);
    drain();

    // edge interrupts, pin 5 then pin 2
    ao_gpio_i <= 8'h00;
    repeat (4) @(posedge clk_i);
    send(OP_WRITE, 12'h804, 32'hFF);
    drain();
    wait_irq(1'b0, '0);
    ao_gpio_i <= 8'h20;
    wait_irq(1'b1, 3'd5);
    ao_gpio_i <= 8'h24;
    wait_irq(1'b1, 3'd2);
    send(OP_WRITE, 12'h804, 32'h04);
    drain();
    check("irq_valid_o", 32'(irq_valid_o), 32'd1);
    check("irq_id_o", 32'(irq_id_o), 32'd5);
    send(OP_WRITE, 12'h804, 32'h20);
    drain();
    check("irq_valid_o", 32'(irq_valid_o), 32'd0);

    $display("checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
